/* aes_dec.f */
hdl/aes_params_pkg.sv
hdl/aes_gf_pkg.sv
hdl/aes_key_sched_fsm.sv
hdl/aes_key_expand.sv
hdl/aes_dec_round.sv
hdl/aes_dec.sv
dv/aes_dec_tb.sv

/* dv/aes_dec_tb.sv */
`timescale 1ns/1ns

module aes_dec_tb;
    import aes_params_pkg::*;

    localparam int num_records  = 8;
    localparam int data_latency = 11;  // Enable sample edge to output.
    localparam int key_delay    = 12;  // fsm_en sample edge to key_ready.
    localparam int reset_cycles = 16;
    localparam int wait_limit   = 200;

    logic   clk;
    logic   rst;
    block_t in;
    key_t   key;
    logic   enable;
    logic   fsm_en;
    block_t out;
    logic   valid_out;
    logic   key_ready;

    logic [127:0] trace [0:3*num_records-1];
    logic [127:0] expect_q [$];
    int unsigned  due_q [$];
    int unsigned  cycle;
    int           key1_idx [$];
    int           key2_idx [$];
    int           run_len;
    int           last_run;
    integer       seed;
    string        test_name;

    aes_dec dut0 (
        .clk       (clk),
        .rst       (rst),
        .in        (in),
        .key       (key),
        .enable    (enable),
        .fsm_en    (fsm_en),
        .out       (out),
        .valid_out (valid_out),
        .key_ready (key_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Pulse fsm_en and count cycles until the round keys are complete.
    task automatic load_key(input logic [127:0] new_key, input string name);
        int count;
        count     = 0;
        test_name = name;
        @(posedge clk);
        key    <= new_key;
        fsm_en <= 1'b1;
        @(posedge clk);
        fsm_en <= 1'b0; // DUT samples the pulse on this edge.
        do begin
            @(negedge clk);
            count++;
        end while (!key_ready && count < wait_limit);
        if (!key_ready) begin
            fail_run({name, ": key_ready never rose after the key load."});
        end else begin
            check_value({name, " key_ready delay"}, key_delay, count);
        end
    endtask

    task automatic send_block(input int idx);
        @(posedge clk);
        in     <= trace[3 * idx + 1];
        enable <= 1'b1;
        expect_q.push_back(trace[3 * idx + 2]);
        // Sampled on the next edge, seen on the negedge before edge +latency.
        due_q.push_back(cycle + 1 + data_latency);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            enable <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int count;
        count = 0;
        while (expect_q.size() != 0 && count < wait_limit) begin
            @(posedge clk);
            count++;
        end
        if (expect_q.size() != 0) begin
            fail_run({test_name, ": timed out waiting for outstanding blocks."});
        end
        @(posedge clk); // Lets the monitor close the valid run.
    endtask

    always @(negedge clk) begin
        logic [127:0] expected;
        int unsigned  due;
        if (rst) begin
            if (valid_out) begin
                run_len++;
                if (expect_q.size() == 0) begin
                    fail_run({test_name, ": valid_out was high with no block in flight."});
                end else begin
                    expected = expect_q.pop_front();
                    due      = due_q.pop_front();
                    check_value({test_name, " plaintext"}, expected, out);
                    check_value({test_name, " arrival cycle"}, due, cycle);
                end
            end else begin
                if (run_len != 0) begin
                    last_run = run_len;
                end
                run_len = 0;
                check_value({test_name, " idle out"}, '0, out);
            end
        end
    end

    initial begin
        int gap;
        seed     = 32'h6033c557;
        rst      = 1'b0;
        in       = '0;
        key      = '0;
        enable   = 1'b0;
        fsm_en   = 1'b0;
        cycle    = 0;
        run_len  = 0;
        last_run = 0;
        test_name = "reset";
        $readmemh("dv/aes_dec_trace.hex", trace);
        if ($isunknown(trace[3 * num_records - 1])) begin
            fail_run("The trace file is missing or shorter than expected.");
        end
        for (int i = 0; i < num_records; i++) begin
            if (trace[3 * i] == trace[0]) begin
                key1_idx.push_back(i);
            end else begin
                key2_idx.push_back(i);
            end
        end
        if (key2_idx.size() == 0) begin
            fail_run("The trace file holds records for only one key.");
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;

        test_name = "idle after reset";
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("reset valid_out", 1'b0, valid_out);
            check_value("reset key_ready", 1'b0, key_ready);
            check_value("reset out", '0, out);
        end

        load_key(trace[0], "first key");
        test_name = "FIPS-197 vector";
        send_block(key1_idx[0]);
        idle_cycles(1);
        wait_drain();

        test_name = "back-to-back";
        last_run  = 0;
        foreach (key1_idx[i]) begin
            send_block(key1_idx[i]);
        end
        idle_cycles(1);
        wait_drain();
        check_value("back-to-back valid run", key1_idx.size(), last_run);

        test_name = "random gaps";
        foreach (key1_idx[i]) begin
            send_block(key1_idx[i]);
            gap = $unsigned($random(seed)) % 4;
            idle_cycles(gap);
        end
        idle_cycles(1);
        wait_drain();

        load_key(trace[3 * key2_idx[0]], "rekey");
        test_name = "second key";
        foreach (key2_idx[i]) begin
            send_block(key2_idx[i]);
            gap = $unsigned($random(seed)) % 3;
            idle_cycles(gap);
        end
        idle_cycles(1);
        wait_drain();

        $display("All tests passed");
        $finish;
    end

endmodule

/* dv/aes_dec_trace.hex */
// Three lines per record: cipher key, ciphertext, expected plaintext.
// First key: FIPS-197 Appendix B, then the SP 800-38A ECB blocks.
2b7e151628aed2a6abf7158809cf4f3c
3925841d02dc09fbdc118597196a0b32
3243f6a8885a308d313198a2e0370734
2b7e151628aed2a6abf7158809cf4f3c
3ad77bb40d7a3660a89ecaf32466ef97
6bc1bee22e409f96e93d7e117393172a
2b7e151628aed2a6abf7158809cf4f3c
f5d3d58503b9699de785895a96fdbaaf
ae2d8a571e03ac9c9eb76fac45af8e51
2b7e151628aed2a6abf7158809cf4f3c
43b1cd7f598ece23881b00e3ed030688
30c81c46a35ce411e5fbc1191a0a52ef
2b7e151628aed2a6abf7158809cf4f3c
7b0c785e27e8ad3f8223207104725dd4
f69f2445df4f9b17ad2b417be66c3710
// Second key: all zero, known-answer blocks.
00000000000000000000000000000000
66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000
00000000000000000000000000000000
0336763e966d92595a567cc9ce537f5e
f34481ec3cc627bacd5dc3fb08f273e6
00000000000000000000000000000000
a9a1631bf4996954ebc093957b234589
9798c4640bad75c7c3227db910174e72

/* hdl/aes_dec.sv */
`timescale 1ns/1ns

module aes_dec (
    input  logic                 clk,
    input  logic                 rst,
    input  aes_params_pkg::block_t in,
    input  aes_params_pkg::key_t   key,
    input  logic                 enable,
    input  logic                 fsm_en,
    output aes_params_pkg::block_t out,
    output logic                 valid_out,
    output logic                 key_ready
);
    import aes_params_pkg::*;

    key_t                    round_key [0:num_rounds];
    block_t                  stage_q [0:num_rounds]; // Index 0 is whitening.
    logic [pipe_latency-1:0] valid_pipe;
    logic                    key_en;
    round_count_t            round_count;
    key_t                    current_key;

    aes_key_sched_fsm fsm0 (
        .clk         (clk),
        .rst         (rst),
        .fsm_en      (fsm_en),
        .key_en      (key_en),
        .round_count (round_count),
        .key_ready   (key_ready)
    );

    aes_key_expand expand0 (
        .clk         (clk),
        .rst         (rst),
        .key         (key),
        .key_en      (key_en),
        .round_count (round_count),
        .current_key (current_key)
    );

    // Key i is loaded while the counter reads i+1.
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i <= num_rounds; i++) begin
                round_key[i] <= '0;
            end
        end else if (key_en) begin
            for (int i = 0; i <= num_rounds; i++) begin
                if (round_count == round_count_t'(i + 1)) begin
                    round_key[i] <= (i == 0) ? key : current_key;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage_q[0] <= '0;
            valid_pipe <= '0;
        end else begin
            stage_q[0] <= in ^ round_key[num_rounds]; // Whitening with k10.
            valid_pipe <= {valid_pipe[pipe_latency-2:0], enable};
        end
    end

    for (genvar g = 0; g < num_rounds; g++) begin : g_round
        aes_dec_round #(
            .inv_mix (g < num_rounds - 1) // Last stage skips inverse MixColumns.
        ) round0 (
            .clk       (clk),
            .rst       (rst),
            .state_in  (stage_q[g]),
            .round_key (round_key[num_rounds - 1 - g]),
            .state_out (stage_q[g + 1])
        );
    end

    assign valid_out = valid_pipe[pipe_latency-1];
    assign out       = valid_out ? stage_q[num_rounds] : '0;

endmodule

/* hdl/aes_dec_round.sv */
`timescale 1ns/1ns

module aes_dec_round #(
    parameter bit inv_mix = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  aes_params_pkg::block_t state_in,
    input  aes_params_pkg::key_t   round_key,
    output aes_params_pkg::block_t state_out
);
    import aes_params_pkg::*;
    import aes_gf_pkg::*;

    block_t sub_bytes;
    block_t keyed;
    block_t mixed;

    // Byte 4c+r sits at row r, column c; row r rotates right by r.
    always_comb begin
        int src;
        int dst;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                dst = 4 * c + r;
                src = 4 * ((c - r + 4) % 4) + r;
                sub_bytes[127 - 8 * dst -: 8] = inv_sbox(state_in[127 - 8 * src -: 8]);
            end
        end
    end

    assign keyed = sub_bytes ^ round_key;

    always_comb begin
        mixed = keyed;
        if (inv_mix) begin
            for (int c = 0; c < 4; c++) begin
                mixed[127 - 32 * c -: 32] = inv_mix_column(keyed[127 - 32 * c -: 32]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_out <= '0;
        end else begin
            state_out <= mixed;
        end
    end

endmodule

/* hdl/aes_gf_pkg.sv */
package aes_gf_pkg;

    typedef logic [7:0] byte_t;

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1.
    function automatic byte_t gf_xtime(byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ x;
            end
            x = gf_xtime(x);
        end
        return p;
    endfunction

    // a^254 is the inverse; zero maps to zero.
    function automatic byte_t gf_inv(byte_t a);
        byte_t sq;
        byte_t acc;
        sq  = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic byte_t sbox(byte_t a);
        byte_t b;
        b = gf_inv(a);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    // Undo the affine map first, then invert.
    function automatic byte_t inv_sbox(byte_t a);
        byte_t b;
        b = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
        return gf_inv(b);
    endfunction

    function automatic logic [31:0] inv_mix_column(logic [31:0] col);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        byte_t b0;
        byte_t b1;
        byte_t b2;
        byte_t b3;
        a0 = col[31:24]; // Row 0.
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        b0 = gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^ gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);
        b1 = gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^ gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);
        b2 = gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^ gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);
        b3 = gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^ gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);
        return {b0, b1, b2, b3};
    endfunction

endpackage

/* hdl/aes_key_expand.sv */
`timescale 1ns/1ns

module aes_key_expand (
    input  logic                         clk,
    input  logic                         rst,
    input  aes_params_pkg::key_t         key,
    input  logic                         key_en,
    input  aes_params_pkg::round_count_t round_count,
    output aes_params_pkg::key_t         current_key
);
    import aes_params_pkg::*;
    import aes_gf_pkg::*;

    key_t        base_key;
    key_t        next_key;
    logic [31:0] rot_word;
    logic [31:0] temp_word;
    byte_t       rcon;
    logic        step;

    assign base_key = (round_count == round_count_t'(1)) ? key : current_key;
    assign rot_word = {base_key[23:0], base_key[31:24]}; // RotWord of w3.
    assign step     = key_en && (round_count != '0)
                      && (round_count <= round_count_t'(num_rounds));

    // Rcon doubles once per round after the first.
    always_comb begin
        rcon = 8'h01;
        for (int i = 1; i < num_rounds; i++) begin
            if (round_count_t'(i) < round_count) begin
                rcon = gf_xtime(rcon);
            end
        end
    end

    always_comb begin
        temp_word = {sbox(rot_word[31:24]), sbox(rot_word[23:16]),
                     sbox(rot_word[15:8]), sbox(rot_word[7:0])};
        temp_word[31:24] = temp_word[31:24] ^ rcon;
        next_key[127:96] = base_key[127:96] ^ temp_word;
        next_key[95:64]  = base_key[95:64] ^ next_key[127:96];
        next_key[63:32]  = base_key[63:32] ^ next_key[95:64];
        next_key[31:0]   = base_key[31:0] ^ next_key[63:32];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            current_key <= '0;
        end else if (step) begin
            current_key <= next_key;
        end
    end

endmodule

/* hdl/aes_key_sched_fsm.sv */
`timescale 1ns/1ns

module aes_key_sched_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fsm_en,
    output logic                        key_en,
    output aes_params_pkg::round_count_t round_count,
    output logic                        key_ready
);
    import aes_params_pkg::*;

    typedef enum logic [1:0] {st_idle, st_expand, st_done} state_t;

    localparam round_count_t last_count = round_count_t'(key_latency - 1);

    state_t state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= st_idle;
            round_count <= '0;
            key_en      <= 1'b0;
            key_ready   <= 1'b0;
        end else begin
            case (state)
                st_expand: begin
                    if (round_count == last_count) begin
                        state       <= st_done;
                        round_count <= '0;
                        key_en      <= 1'b0;
                        key_ready   <= 1'b1; // Last key lands this edge.
                    end else begin
                        round_count <= round_count + 1'b1;
                    end
                end
                default: begin // Idle or done.
                    if (fsm_en) begin
                        state       <= st_expand;
                        round_count <= round_count_t'(1);
                        key_en      <= 1'b1;
                        key_ready   <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/aes_params_pkg.sv */
package aes_params_pkg;

    typedef logic [127:0] block_t;       // State or text block.
    typedef logic [127:0] key_t;         // Cipher key or round key.
    typedef logic [3:0]   round_count_t; // Key schedule step.

    localparam int num_rounds   = 10;
    localparam int pipe_latency = 11;    // Enable to valid_out.
    localparam int key_latency  = 12;    // fsm_en to key_ready.

endpackage
